// File: source/bridge_cfg.svh
// Bridge widths, queue depths and AHB constants; include wherever a module is sized by them.
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define ID_WIDTH 4

// Queue depths must be powers of two.
`define CMD_DEPTH 4
`define WDATA_DEPTH 4
`define RDATA_DEPTH 4
`define BRESP_DEPTH 4

`define AFULL_GAP 2 // Free entries left when almost_full rises.

`define HSIZE_FULL 3'd2 // Word transfers on a 32-bit bus.

`endif

// File: source/bridge_pkg.sv
// Shared bridge types for the RTL and the testbench.
`include "bridge_cfg.svh"

package bridge_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`ID_WIDTH-1:0] id_t;
	typedef logic [7:0] len_t; // Beats minus one.
	typedef logic [2:0] prot_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Queue entries.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		addr_t addr;
		id_t   id;
		len_t  len;
		prot_t prot;
	} axi_cmd_t;

	typedef struct packed {
		data_t data;
	} wbeat_t;

	typedef struct packed {
		data_t data;
		id_t   id;
		logic  last;
		logic  err;
	} rbeat_t;

	typedef struct packed {
		id_t  id;
		logic err;
	} bresp_t;

	typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} master_state_t;

endpackage

// File: source/async_fifo.sv
// Dual-clock FIFO with Gray pointers and first-word-fall-through read for every bridge crossing.
`timescale 1ns/1ps

module async_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4,
	parameter int AFULL_GAP = 1
) (
	input  logic             w_clk,
	input  logic             r_clk,
	input  logic             reset,
	input  logic             wr,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty,
	output logic             almost_full
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_LEVEL = (AW+1)'(DEPTH);
	localparam logic [AW:0] AFULL_LEVEL = (AW+1)'(DEPTH - AFULL_GAP);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0] w_bin;
	logic [AW:0] w_bin_next;
	logic [AW:0] w_gray;
	logic [AW:0] r_bin;
	logic [AW:0] r_bin_next;
	logic [AW:0] r_gray;
	logic [AW:0] r_gray_w1; // Read pointer in the write domain.
	logic [AW:0] r_gray_w2;
	logic [AW:0] w_gray_r1; // Write pointer in the read domain.
	logic [AW:0] w_gray_r2;
	logic [AW:0] w_count;
	logic        w_en;
	logic        r_en;

	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW - 1; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write domain.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign w_en = wr & ~full;
	assign w_bin_next = w_bin + 1'b1;

	always_ff @(posedge w_clk) begin
		if (reset) begin
			w_bin <= '0;
			w_gray <= '0;
			r_gray_w1 <= '0;
			r_gray_w2 <= '0;
		end else begin
			if (w_en) begin
				w_bin <= w_bin_next;
				w_gray <= w_bin_next ^ (w_bin_next >> 1);
			end
			r_gray_w1 <= r_gray;
			r_gray_w2 <= r_gray_w1;
		end
	end

	always_ff @(posedge w_clk) begin
		if (w_en)
			mem[w_bin[AW-1:0]] <= wr_data;
	end

	assign w_count = w_bin - gray2bin(r_gray_w2); // Pessimistic by the sync delay.
	assign full = (w_count == FULL_LEVEL);
	assign almost_full = (w_count >= AFULL_LEVEL);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read domain.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign r_en = rd & ~empty;
	assign r_bin_next = r_bin + 1'b1;

	always_ff @(posedge r_clk) begin
		if (reset) begin
			r_bin <= '0;
			r_gray <= '0;
			w_gray_r1 <= '0;
			w_gray_r2 <= '0;
		end else begin
			if (r_en) begin
				r_bin <= r_bin_next;
				r_gray <= r_bin_next ^ (r_bin_next >> 1);
			end
			w_gray_r1 <= w_gray;
			w_gray_r2 <= w_gray_r1;
		end
	end

	assign empty = (r_gray == w_gray_r2);
	assign rd_data = mem[r_bin[AW-1:0]]; // Head entry shown while not empty.

endmodule

// File: source/ahb_burst_master.sv
// AHB master that replays queued AXI bursts as INCR bursts and returns read beats and responses.
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module ahb_burst_master (
	input  logic                 hclk,
	input  logic                 reset,
	input  bridge_pkg::axi_cmd_t rcmd,
	input  logic                 rcmd_empty,
	output logic                 rcmd_rd,
	input  bridge_pkg::axi_cmd_t wcmd,
	input  logic                 wcmd_empty,
	output logic                 wcmd_rd,
	input  bridge_pkg::wbeat_t   wbeat,
	input  logic                 wbeat_empty,
	output logic                 wbeat_rd,
	output bridge_pkg::rbeat_t   rbeat,
	output logic                 rbeat_wr,
	input  logic                 rbeat_afull,
	output bridge_pkg::bresp_t   bresp,
	output logic                 bresp_wr,
	input  logic                 bresp_afull,
	output bridge_pkg::addr_t    haddr,
	output logic [1:0]           htrans,
	output logic                 hwrite,
	output logic [2:0]           hsize,
	output logic [2:0]           hburst,
	output logic [3:0]           hprot,
	output bridge_pkg::data_t    hwdata,
	input  bridge_pkg::data_t    hrdata,
	input  logic                 hready,
	input  logic                 hresp
);

	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_BUSY = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ = 2'b11;
	localparam logic [2:0] HBURST_INCR = 3'b001;
	localparam bridge_pkg::addr_t ADDR_STEP = bridge_pkg::addr_t'(`DATA_WIDTH / 8);

	bridge_pkg::master_state_t state;
	bridge_pkg::master_state_t state_next;
	bridge_pkg::axi_cmd_t      cmd_sel;
	bridge_pkg::id_t           cur_id;
	bridge_pkg::len_t          beats_left;
	logic prio_wr;     // Write queue wins the next tie.
	logic first;       // Next beat is the NONSEQ one.
	logic dp_valid;    // A real transfer is in its data phase.
	logic err_acc;
	logic rd_ok;
	logic wr_ok;
	logic beat_stall;
	logic addr_accept;
	logic last_beat;
	logic dp_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command selection.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rd_ok = ~rcmd_empty & ~rbeat_afull;
	assign wr_ok = ~wcmd_empty & ~bresp_afull;
	assign rcmd_rd = (state == bridge_pkg::IDLE) & rd_ok & (~wr_ok | ~prio_wr);
	assign wcmd_rd = (state == bridge_pkg::IDLE) & wr_ok & (~rd_ok | prio_wr);
	assign cmd_sel = wcmd_rd ? wcmd : rcmd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address and data phases.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign beat_stall = hwrite ? wbeat_empty : rbeat_afull;
	assign addr_accept = (state == bridge_pkg::ADDR) & hready & ~beat_stall;
	assign last_beat = (beats_left == '0);
	assign wbeat_rd = addr_accept & hwrite; // Data is held for the next cycle.
	assign dp_done = dp_valid & hready;

	always_comb begin
		htrans = HTRANS_IDLE;
		if (state == bridge_pkg::ADDR) begin
			if (beat_stall)
				htrans = first ? HTRANS_IDLE : HTRANS_BUSY; // No BUSY before NONSEQ.
			else
				htrans = first ? HTRANS_NONSEQ : HTRANS_SEQ;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			bridge_pkg::IDLE:
				if (rcmd_rd | wcmd_rd)
					state_next = bridge_pkg::ADDR;
			bridge_pkg::ADDR:
				if (addr_accept & last_beat)
					state_next = bridge_pkg::DATA;
			bridge_pkg::DATA:
				if (hready)
					state_next = hwrite ? bridge_pkg::RESP : bridge_pkg::IDLE;
			default:
				state_next = bridge_pkg::IDLE;
		endcase
	end

	always_ff @(posedge hclk) begin
		if (reset) begin
			state <= bridge_pkg::IDLE;
			prio_wr <= 1'b0;
			first <= 1'b0;
			dp_valid <= 1'b0;
			hwrite <= 1'b0;
		end else begin
			state <= state_next;
			if (rcmd_rd | wcmd_rd) begin
				prio_wr <= rcmd_rd;
				hwrite <= wcmd_rd;
				first <= 1'b1;
			end else if (addr_accept) begin
				first <= 1'b0;
			end
			if (hready)
				dp_valid <= addr_accept;
		end
	end

	always_ff @(posedge hclk) begin
		if (rcmd_rd | wcmd_rd) begin
			haddr <= cmd_sel.addr;
			cur_id <= cmd_sel.id;
			beats_left <= cmd_sel.len;
			hprot <= {2'b00, cmd_sel.prot[0], ~cmd_sel.prot[2]};
			err_acc <= 1'b0;
		end else begin
			if (addr_accept) begin
				haddr <= haddr + ADDR_STEP;
				beats_left <= beats_left - 1'b1;
			end
			if (dp_done & hwrite)
				err_acc <= err_acc | hresp; // Sticky over the burst.
		end
		if (wbeat_rd)
			hwdata <= wbeat.data;
	end

	// Only the final data phase runs in DATA.
	assign rbeat = '{data: hrdata, id: cur_id, last: (state == bridge_pkg::DATA), err: hresp};
	assign rbeat_wr = dp_done & ~hwrite;
	assign bresp = '{id: cur_id, err: err_acc};
	assign bresp_wr = (state == bridge_pkg::RESP);

	assign hsize = `HSIZE_FULL;
	assign hburst = HBURST_INCR;

endmodule

// File: source/axi2ahb_bridge.sv
// AXI-to-AHB bridge top; AXI slave on aclk, AHB master on hclk, joined by five async FIFOs.
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module axi2ahb_bridge (
	input  logic              aclk,
	input  logic              hclk,
	input  logic              reset,
	// AXI read address.
	input  bridge_pkg::addr_t araddr,
	input  bridge_pkg::id_t   arid,
	input  bridge_pkg::len_t  arlen,
	input  bridge_pkg::prot_t arprot,
	input  logic              arvalid,
	output logic              arready,
	// AXI write address.
	input  bridge_pkg::addr_t awaddr,
	input  bridge_pkg::id_t   awid,
	input  bridge_pkg::len_t  awlen,
	input  bridge_pkg::prot_t awprot,
	input  logic              awvalid,
	output logic              awready,
	// AXI write data.
	input  bridge_pkg::data_t wdata,
	input  logic              wlast,   // Beats are counted from awlen.
	input  logic              wvalid,
	output logic              wready,
	// AXI write response.
	output bridge_pkg::id_t   bid,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	// AXI read data.
	output bridge_pkg::data_t rdata,
	output bridge_pkg::id_t   rid,
	output logic [1:0]        rresp,
	output logic              rlast,
	output logic              rvalid,
	input  logic              rready,
	// AHB master.
	output bridge_pkg::addr_t haddr,
	output logic [1:0]        htrans,
	output logic              hwrite,
	output logic [2:0]        hsize,
	output logic [2:0]        hburst,
	output logic [3:0]        hprot,
	output bridge_pkg::data_t hwdata,
	input  bridge_pkg::data_t hrdata,
	input  logic              hready,
	input  logic              hresp
);

	bridge_pkg::axi_cmd_t rcmd_in;
	bridge_pkg::axi_cmd_t rcmd_head;
	bridge_pkg::axi_cmd_t wcmd_in;
	bridge_pkg::axi_cmd_t wcmd_head;
	bridge_pkg::wbeat_t   wbeat_in;
	bridge_pkg::wbeat_t   wbeat_head;
	bridge_pkg::rbeat_t   rbeat_push;
	bridge_pkg::rbeat_t   rbeat_head;
	bridge_pkg::bresp_t   bresp_push;
	bridge_pkg::bresp_t   bresp_head;
	logic rcmd_full;
	logic rcmd_empty;
	logic rcmd_rd;
	logic wcmd_full;
	logic wcmd_empty;
	logic wcmd_rd;
	logic wbeat_full;
	logic wbeat_empty;
	logic wbeat_rd;
	logic rbeat_empty;
	logic rbeat_wr;
	logic rbeat_afull;
	logic bresp_empty;
	logic bresp_wr;
	logic bresp_afull;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI side packing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rcmd_in = '{addr: araddr, id: arid, len: arlen, prot: arprot};
	assign wcmd_in = '{addr: awaddr, id: awid, len: awlen, prot: awprot};
	assign wbeat_in = '{data: wdata};
	assign arready = ~rcmd_full;
	assign awready = ~wcmd_full;
	assign wready = ~wbeat_full;

	assign rvalid = ~rbeat_empty;
	assign rdata = rbeat_head.data;
	assign rid = rbeat_head.id;
	assign rlast = rbeat_head.last;
	assign rresp = rbeat_head.err ? 2'b10 : 2'b00; // SLVERR or OKAY.
	assign bvalid = ~bresp_empty;
	assign bid = bresp_head.id;
	assign bresp = bresp_head.err ? 2'b10 : 2'b00;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Clock crossings.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	async_fifo #(.WIDTH($bits(bridge_pkg::axi_cmd_t)), .DEPTH(`CMD_DEPTH), .AFULL_GAP(`AFULL_GAP))
	rcmdq (
		.w_clk(aclk), .r_clk(hclk), .reset(reset),
		.wr(arvalid & ~rcmd_full), .wr_data(rcmd_in), .rd(rcmd_rd), .rd_data(rcmd_head),
		.full(rcmd_full), .empty(rcmd_empty), .almost_full()
	);

	async_fifo #(.WIDTH($bits(bridge_pkg::axi_cmd_t)), .DEPTH(`CMD_DEPTH), .AFULL_GAP(`AFULL_GAP))
	wcmdq (
		.w_clk(aclk), .r_clk(hclk), .reset(reset),
		.wr(awvalid & ~wcmd_full), .wr_data(wcmd_in), .rd(wcmd_rd), .rd_data(wcmd_head),
		.full(wcmd_full), .empty(wcmd_empty), .almost_full()
	);

	async_fifo #(.WIDTH($bits(bridge_pkg::wbeat_t)), .DEPTH(`WDATA_DEPTH), .AFULL_GAP(`AFULL_GAP))
	wdq (
		.w_clk(aclk), .r_clk(hclk), .reset(reset),
		.wr(wvalid & ~wbeat_full), .wr_data(wbeat_in), .rd(wbeat_rd), .rd_data(wbeat_head),
		.full(wbeat_full), .empty(wbeat_empty), .almost_full()
	);

	// Return path; the master keeps these from filling.
	async_fifo #(.WIDTH($bits(bridge_pkg::rbeat_t)), .DEPTH(`RDATA_DEPTH), .AFULL_GAP(`AFULL_GAP))
	rdq (
		.w_clk(hclk), .r_clk(aclk), .reset(reset),
		.wr(rbeat_wr), .wr_data(rbeat_push), .rd(rready & ~rbeat_empty), .rd_data(rbeat_head),
		.full(), .empty(rbeat_empty), .almost_full(rbeat_afull)
	);

	async_fifo #(.WIDTH($bits(bridge_pkg::bresp_t)), .DEPTH(`BRESP_DEPTH), .AFULL_GAP(`AFULL_GAP))
	brespq (
		.w_clk(hclk), .r_clk(aclk), .reset(reset),
		.wr(bresp_wr), .wr_data(bresp_push), .rd(bready & ~bresp_empty), .rd_data(bresp_head),
		.full(), .empty(bresp_empty), .almost_full(bresp_afull)
	);

	ahb_burst_master master (
		.hclk(hclk), .reset(reset),
		.rcmd(rcmd_head), .rcmd_empty(rcmd_empty), .rcmd_rd(rcmd_rd),
		.wcmd(wcmd_head), .wcmd_empty(wcmd_empty), .wcmd_rd(wcmd_rd),
		.wbeat(wbeat_head), .wbeat_empty(wbeat_empty), .wbeat_rd(wbeat_rd),
		.rbeat(rbeat_push), .rbeat_wr(rbeat_wr), .rbeat_afull(rbeat_afull),
		.bresp(bresp_push), .bresp_wr(bresp_wr), .bresp_afull(bresp_afull),
		.haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
		.hburst(hburst), .hprot(hprot), .hwdata(hwdata),
		.hrdata(hrdata), .hready(hready), .hresp(hresp)
	);

endmodule

// File: test/tb_clock_gen.sv
// Free-running testbench clock with a set period and phase offset; one instance per clock.
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD = 100.0,
	parameter real PHASE = 0.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		#(PHASE);
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// File: test/ahb_slave_model.sv
// AHB memory slave for the bridge testbench with random wait states, an error page and an hprot log.
`timescale 1ns/1ps

module ahb_slave_model #(
	parameter logic [3:0] ERROR_PAGE = 4'he,
	parameter int SEED = 32'h3782
) (
	input  logic              hclk,
	input  logic              reset,
	input  bridge_pkg::addr_t haddr,
	input  logic [1:0]        htrans,
	input  logic              hwrite,
	input  logic [3:0]        hprot,
	input  bridge_pkg::data_t hwdata,
	output bridge_pkg::data_t hrdata,
	output logic              hready,
	output logic              hresp
);

	bridge_pkg::data_t mem [bridge_pkg::addr_t];
	logic [4:0] hprot_log [$]; // {hwrite, hprot} for each burst.
	bridge_pkg::addr_t dp_addr;
	logic dp_active;
	logic dp_write;
	logic dp_err;
	int waits;
	integer seed = SEED;

	always @(posedge hclk) begin
		if (reset) begin
			dp_active = 1'b0;
			waits = 0;
		end else if (dp_active && waits != 0) begin
			waits = waits - 1; // Wait state.
		end else begin
			if (dp_active && dp_write && !dp_err)
				mem[dp_addr] = hwdata;
			if (htrans == 2'b10)
				hprot_log.push_back({hwrite, hprot});
			dp_active = htrans[1];
			dp_addr = haddr;
			dp_write = hwrite;
			dp_err = (haddr[15:12] == ERROR_PAGE);
			waits = htrans[1] ? int'($unsigned($random(seed)) % 3) : 0;
		end
		#1; // Responses change just after the edge.
		hready = !dp_active || waits == 0;
		hresp = dp_active && waits == 0 && dp_err; // One-cycle error.
		hrdata = (dp_active && mem.exists(dp_addr)) ? mem[dp_addr] : ~dp_addr;
	end

endmodule

// File: test/tb_axi2ahb.sv
// Testbench top for the AXI-to-AHB bridge; random bursts checked against a memory model.
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_axi2ahb;

	localparam logic [3:0] ERROR_PAGE = 4'he;
	localparam int STEP = `DATA_WIDTH / 8;
	localparam logic [2:0] HSIZE_WORD = 3'($clog2(STEP)); // AHB size is log2 of the bytes.
	localparam logic [2:0] HBURST_INCR = 3'b001;
	localparam int MARGIN = 1000; // Watchdog slack in aclk cycles.

	typedef struct packed {
		bridge_pkg::data_t data;
		logic              last;
	} wdrive_t;

	typedef struct packed {
		bridge_pkg::rbeat_t beat;
		logic               known; // Model holds the data.
	} exp_rbeat_t;

	logic aclk;
	logic hclk;
	logic reset;
	bridge_pkg::addr_t araddr, awaddr, haddr;
	bridge_pkg::id_t   arid, awid, bid, rid;
	bridge_pkg::len_t  arlen, awlen;
	bridge_pkg::prot_t arprot, awprot;
	bridge_pkg::data_t wdata, rdata, hwdata, hrdata;
	logic [1:0] bresp, rresp, htrans;
	logic [2:0] hsize, hburst;
	logic [3:0] hprot;
	logic arvalid, arready, awvalid, awready, wlast, wvalid, wready;
	logic bvalid, bready, rlast, rvalid, rready, hwrite, hready, hresp;

	bridge_pkg::data_t model_mem [bridge_pkg::addr_t];
	bridge_pkg::axi_cmd_t aw_q [$];
	bridge_pkg::axi_cmd_t ar_q [$];
	wdrive_t w_q [$];
	exp_rbeat_t exp_r [$];
	bridge_pkg::bresp_t exp_b [$];
	logic [3:0] exp_rprot [$];
	logic [3:0] exp_wprot [$];
	integer seed = 32'h3782;
	int total_beats = 0;
	int checks = 0;
	int errors = 0;
	int test_num = 0;
	int test_base = 0;
	logic bp_en = 1'b0;

	tb_clock_gen #(.PERIOD(100.0), .PHASE(0.0)) aclk_gen (.clk(aclk));
	tb_clock_gen #(.PERIOD(100.0), .PHASE(30.0)) hclk_gen (.clk(hclk));

	axi2ahb_bridge uut (.*);

	ahb_slave_model #(.ERROR_PAGE(ERROR_PAGE)) slave (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Model and checking.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI prot[2] marks an instruction fetch and prot[0] a privileged access.
	function automatic logic [3:0] map_hprot(input bridge_pkg::prot_t prot);
		logic [3:0] h;
		h = 4'b0000;
		h[0] = !prot[2]; // Data access.
		h[1] = prot[0]; // Privileged.
		return h;
	endfunction

	function automatic logic in_error_page(input bridge_pkg::addr_t a);
		return a[15:12] == ERROR_PAGE;
	endfunction

	// 64-byte slots keep a 16-beat burst inside 1 KB.
	function automatic bridge_pkg::addr_t pick_addr(input int page, input int pages);
		logic [3:0] pg;
		logic [5:0] slot;
		pg = 4'(page + $unsigned($random(seed)) % pages);
		slot = 6'($random(seed));
		return {16'h0000, pg, slot, 6'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic queue_write(input bridge_pkg::addr_t addr, input int beats);
		bridge_pkg::prot_t prot;
		bridge_pkg::id_t id;
		bridge_pkg::data_t d;
		logic err;
		prot = 3'($random(seed));
		id = 4'($random(seed));
		err = 1'b0;
		aw_q.push_back({addr, id, 8'(beats - 1), prot});
		for (int i = 0; i < beats; i++) begin
			d = $random(seed);
			w_q.push_back({d, 1'(i == beats - 1)});
			if (in_error_page(addr + STEP * i))
				err = 1'b1; // Slave drops the write.
			else
				model_mem[addr + STEP * i] = d;
		end
		exp_b.push_back({id, err});
		exp_wprot.push_back(map_hprot(prot));
		total_beats += beats;
	endtask

	task automatic queue_read(input bridge_pkg::addr_t addr, input int beats);
		bridge_pkg::prot_t prot;
		bridge_pkg::id_t id;
		bridge_pkg::addr_t a;
		exp_rbeat_t e;
		prot = 3'($random(seed));
		id = 4'($random(seed));
		ar_q.push_back({addr, id, 8'(beats - 1), prot});
		for (int i = 0; i < beats; i++) begin
			a = addr + STEP * i;
			e.beat.data = model_mem.exists(a) ? model_mem[a] : '0;
			e.beat.id = id;
			e.beat.last = (i == beats - 1);
			e.beat.err = in_error_page(a);
			e.known = model_mem.exists(a);
			exp_r.push_back(e);
		end
		exp_rprot.push_back(map_hprot(prot));
		total_beats += beats;
	endtask

	task automatic wait_idle();
		while (exp_r.size() != 0 || exp_b.size() != 0)
			@(negedge aclk);
	endtask

	task automatic end_test(input string name);
		logic [4:0] entry;
		wait_idle();
		while (slave.hprot_log.size() != 0) begin
			entry = slave.hprot_log.pop_front();
			if (entry[4] ? exp_wprot.size() == 0 : exp_rprot.size() == 0) begin
				$display("AHB burst started with no matching AXI command");
				errors++;
			end else if (entry[4]) begin
				check_value("hprot", entry[3:0], exp_wprot.pop_front());
			end else begin
				check_value("hprot", entry[3:0], exp_rprot.pop_front());
			end
		end
		if (exp_wprot.size() != 0 || exp_rprot.size() != 0) begin
			$display("AXI command completed with no NONSEQ burst start on AHB");
			errors++;
			exp_wprot.delete();
			exp_rprot.delete();
		end
		test_num++;
		$display("Test %0d, %s: %0d errors", test_num, name, errors - test_base);
		test_base = errors;
	endtask

	// Every NONSEQ or SEQ transfer is a word-wide INCR beat.
	always @(negedge hclk) begin
		if (htrans[1]) begin
			check_value("hsize", hsize, HSIZE_WORD);
			check_value("hburst", hburst, HBURST_INCR);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI channel drivers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge aclk) begin
		if (!awvalid || awready) begin
			#1;
			awvalid = aw_q.size() != 0;
			if (awvalid)
				{awaddr, awid, awlen, awprot} = aw_q.pop_front();
		end
	end

	always @(posedge aclk) begin
		if (!wvalid || wready) begin
			#1;
			wvalid = w_q.size() != 0;
			if (wvalid)
				{wdata, wlast} = w_q.pop_front();
		end
	end

	always @(posedge aclk) begin
		if (!arvalid || arready) begin
			#1;
			arvalid = ar_q.size() != 0;
			if (arvalid)
				{araddr, arid, arlen, arprot} = ar_q.pop_front();
		end
	end

	initial begin : response_monitor
		exp_rbeat_t er;
		bridge_pkg::bresp_t eb;
		forever begin
			@(posedge aclk);
			if (rvalid && rready) begin
				if (exp_r.size() == 0) begin
					$display("Read beat arrived with no read outstanding");
					errors++;
				end else begin
					er = exp_r.pop_front();
					check_value("rid", rid, er.beat.id);
					check_value("rlast", rlast, er.beat.last);
					check_value("rresp", rresp, er.beat.err ? 2'b10 : 2'b00);
					if (er.known)
						check_value("rdata", rdata, er.beat.data);
				end
			end
			if (bvalid && bready) begin
				if (exp_b.size() == 0) begin
					$display("Write response arrived with no write outstanding");
					errors++;
				end else begin
					eb = exp_b.pop_front();
					check_value("bid", bid, eb.id);
					check_value("bresp", bresp, eb.err ? 2'b10 : 2'b00);
				end
			end
			#1;
			rready = bp_en ? 1'($random(seed)) : 1'b1;
			bready = bp_en ? 1'($random(seed)) : 1'b1;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= total_beats * 20 + MARGIN) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout: traffic did not complete within %0d aclk cycles", cycles);
		$display(">>> FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : main
		bridge_pkg::addr_t wr_addr [6];
		int wr_len [6];
		bridge_pkg::addr_t bp_addr [6];
		int bp_len [6];
		reset = 1'b1;
		{araddr, arid, arlen, arprot, arvalid} = '0;
		{awaddr, awid, awlen, awprot, awvalid} = '0;
		{wdata, wlast, wvalid} = '0;
		rready = 1'b1;
		bready = 1'b1;
		repeat (3) @(posedge aclk);
		@(posedge hclk); // Covers three hclk edges as well.
		@(posedge aclk);
		#1 reset = 1'b0;
		@(negedge aclk);

		check_value("rvalid", rvalid, 1'b0);
		check_value("bvalid", bvalid, 1'b0);
		check_value("htrans", htrans, 2'b00);
		check_value("arready", arready, 1'b1);
		check_value("awready", awready, 1'b1);
		check_value("wready", wready, 1'b1);
		end_test("reset state");

		queue_write(32'h0000_1040, 1);
		wait_idle();
		queue_read(32'h0000_1040, 1);
		end_test("single write and read-back");

		for (int i = 0; i < 6; i++) begin
			wr_addr[i] = pick_addr(0, 7);
			wr_len[i] = 1 + $unsigned($random(seed)) % 16;
			queue_write(wr_addr[i], wr_len[i]);
		end
		wait_idle();
		for (int i = 0; i < 6; i++)
			queue_read(wr_addr[i], wr_len[i]);
		end_test("random bursts");

		bp_addr[0] = pick_addr(ERROR_PAGE, 1);
		bp_addr[1] = pick_addr(5, 1);
		queue_write(bp_addr[0], 4);
		queue_write(bp_addr[1], 5);
		wait_idle();
		queue_read(bp_addr[1], 5);
		queue_read(bp_addr[0], 4);
		end_test("error page");

		bp_en = 1'b1;
		for (int i = 0; i < 6; i++) begin
			bp_addr[i] = pick_addr(7, 7);
			bp_len[i] = 1 + $unsigned($random(seed)) % 16;
			queue_write(bp_addr[i], bp_len[i]);
		end
		wait_idle();
		for (int i = 0; i < 6; i++)
			queue_read(bp_addr[i], bp_len[i]);
		end_test("back-pressure");
		bp_en = 1'b0;

		// Writes land in pages 7 to 13 and reads come from pages 0 to 6.
		for (int i = 0; i < 4; i++) begin
			queue_write(pick_addr(7, 7), 1 + $unsigned($random(seed)) % 16);
			queue_read(wr_addr[i], wr_len[i]);
		end
		end_test("concurrent traffic");

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: project.f
+incdir+source
source/bridge_pkg.sv
source/async_fifo.sv
source/ahb_burst_master.sv
source/axi2ahb_bridge.sv
test/tb_clock_gen.sv
test/ahb_slave_model.sv
test/tb_axi2ahb.sv
